// ==== filelist.f ====
+incdir+source
source/graph_reduce_pkg.sv
source/demux_bus.sv
source/lane_engine.sv
source/result_collector.sv
source/graph_reduce_top.sv
sim/graph_reduce_tb.sv

// ==== sim/graph_reduce_tb.sv ====
// --------------------
// Table-driven testbench for the reduction fabric
// Per-lane reference model, results checked in flush order with latency
// --------------------

`timescale 1ns/10ps
`default_nettype none

`include "graph_reduce_defs.svh"

module graph_reduce_tb;

	import graph_reduce_pkg::*;

	localparam int MAX_ENTRIES   = 64;
	localparam int SEED          = 32'h13c6_5073;
	localparam int FLUSH_SPACING = 8;
	localparam int MIN_LATENCY   = 7;
	localparam int MAX_LATENCY   = 10;

	logic                      clock;
	logic                      rstn;
	lane_sel_t                 job_sel;
	logic [`GR_DATA_WIDTH-1:0] job_data;
	logic                      job_valid;
	value_t                    result_value;
	lane_sel_t                 result_lane;
	logic                      result_valid;

	// Stimulus table, one word plus its trailing idle cycles per entry
	lane_sel_t tbl_lane [0:MAX_ENTRIES-1];
	lane_op_t  tbl_op [0:MAX_ENTRIES-1];
	value_t    tbl_operand [0:MAX_ENTRIES-1];
	int        tbl_gap [0:MAX_ENTRIES-1];
	int        n_entries;
	int        table_cycles;
	int        last_flush [0:`GR_LANES-1];

	// Reference model and outstanding flushes
	value_t    model_acc [0:`GR_LANES-1];
	value_t    exp_value_q [$];
	lane_sel_t exp_lane_q [$];
	int        exp_stamp_q [$];

	int cycle;
	int timeout_cycles = 0;
	int value_errors;
	int lane_errors;
	int other_errors;

	graph_reduce_top DUT (
		.clock        (clock),
		.rstn         (rstn),
		.job_sel      (job_sel),
		.job_data     (job_data),
		.job_valid    (job_valid),
		.result_value (result_value),
		.result_lane  (result_lane),
		.result_valid (result_valid)
	);

	initial begin
		clock = 1'b0;
		forever #2 clock = ~clock;
	end

	always @(posedge clock) begin
		cycle <= cycle + 1;
	end

	// --------------------
	// Compare tasks
	// --------------------

	task automatic check_value(input string name, input value_t expected, input value_t actual);
		if (actual !== expected) begin
			$display("[FAIL] %0t %s expected %h got %h", $time, name, expected, actual);
			value_errors++;
		end
	endtask

	task automatic check_lane(input string name, input lane_sel_t expected,
			input lane_sel_t actual);
		if (actual !== expected) begin
			$display("[FAIL] %0t %s expected %0d got %0d", $time, name, expected, actual);
			lane_errors++;
		end
	endtask

	// --------------------
	// Table construction
	// --------------------

	// Stretches the previous gap when a flush comes too soon on its lane
	task automatic add_entry(input lane_sel_t lane, input lane_op_t op, input value_t operand,
			input int gap);
		int since;
		since = table_cycles - last_flush[lane];
		if (op == OP_FLUSH && since < FLUSH_SPACING) begin
			tbl_gap[n_entries-1] += FLUSH_SPACING - since;
			table_cycles += FLUSH_SPACING - since;
		end
		if (op == OP_FLUSH) begin
			last_flush[lane] = table_cycles;
		end
		tbl_lane[n_entries]    = lane;
		tbl_op[n_entries]      = op;
		tbl_operand[n_entries] = operand;
		tbl_gap[n_entries]     = gap;
		table_cycles += 1 + gap;
		n_entries++;
	endtask

	task automatic build_table();
		int r;
		lane_op_t op;
		n_entries    = 0;
		table_cycles = 0;
		for (int l = 0; l < `GR_LANES; l++) begin
			last_flush[l] = -100;
		end
		// Sum past 30 bits on lane 0
		add_entry(2'd0, OP_ADD, 30'h3fff_fff0, 0);
		add_entry(2'd0, OP_ADD, 30'h0000_0025, 2);
		add_entry(2'd0, OP_FLUSH, 30'h155, 1);
		// Running max, then an add on top of it
		add_entry(2'd1, OP_MAX, 30'd100, 0);
		add_entry(2'd1, OP_MAX, 30'd7, 3);
		add_entry(2'd1, OP_MAX, 30'h0123_4567, 0);
		add_entry(2'd1, OP_ADD, 30'd5, 0);
		add_entry(2'd1, OP_FLUSH, 30'h0, 0);
		// Clear drops the 50, second flush reads zero
		add_entry(2'd2, OP_ADD, 30'd50, 4);
		add_entry(2'd2, OP_CLEAR, 30'h2aa, 0);
		add_entry(2'd2, OP_ADD, 30'd9, 0);
		add_entry(2'd2, OP_FLUSH, 30'h0, 0);
		add_entry(2'd2, OP_FLUSH, 30'h0, 10);
		// Distinct sums, then all lanes flushed back to back
		for (int l = 0; l < `GR_LANES; l++) begin
			add_entry(lane_sel_t'(l), OP_ADD, value_t'(1000 * (l + 1)), 0);
		end
		for (int l = 0; l < `GR_LANES; l++) begin
			add_entry(lane_sel_t'(l), OP_FLUSH, 30'h0, (l == `GR_LANES - 1) ? 2 : 0);
		end
		// Random mix, adds weighted heaviest
		for (int n = 0; n < 24; n++) begin
			r = $urandom_range(0, 7);
			case (r)
				0, 1, 2, 3: op = OP_ADD;
				4, 5:       op = OP_MAX;
				6:          op = OP_CLEAR;
				default:    op = OP_FLUSH;
			endcase
			add_entry(lane_sel_t'($urandom_range(0, 3)), op, value_t'($urandom()),
				$urandom_range(0, 2));
		end
		// Drain every accumulator
		for (int l = 0; l < `GR_LANES; l++) begin
			add_entry(lane_sel_t'(l), OP_FLUSH, 30'h0, 0);
		end
	endtask

	// --------------------
	// Driver and model
	// --------------------

	// Garbage on the bus with the strobe low
	task automatic drive_idle();
		job_sel   <= lane_sel_t'($urandom());
		job_data  <= $urandom();
		job_valid <= 1'b0;
	endtask

	// Counter still holds the previous cycle when called on an edge
	task automatic apply_model(input int i);
		value_t acc;
		acc = model_acc[tbl_lane[i]];
		case (tbl_op[i])
			OP_ADD: acc = acc + tbl_operand[i];
			OP_MAX: acc = (tbl_operand[i] > acc) ? tbl_operand[i] : acc;
			OP_CLEAR: acc = '0;
			default: begin
				exp_value_q.push_back(acc);
				exp_lane_q.push_back(tbl_lane[i]);
				exp_stamp_q.push_back(cycle + 1);
				acc = '0;
			end
		endcase
		model_acc[tbl_lane[i]] = acc;
	endtask

	// --------------------
	// Monitor
	// --------------------

	// Results leave in flush order
	// Only one word enters per cycle so no two lanes pend at once
	task automatic match_result();
		int latency;
		if (exp_lane_q.size() == 0) begin
			$display("Result on lane %0d at %0t with no flush outstanding", result_lane, $time);
			other_errors++;
		end else begin
			check_value("result_value", exp_value_q[0], result_value);
			check_lane("result_lane", exp_lane_q[0], result_lane);
			latency = cycle - exp_stamp_q[0];
			if (latency < MIN_LATENCY || latency > MAX_LATENCY) begin
				$display("Result on lane %0d took %0d cycles at %0t", result_lane, latency, $time);
				other_errors++;
			end
			exp_value_q.delete(0);
			exp_lane_q.delete(0);
			exp_stamp_q.delete(0);
		end
	endtask

	// Registered outputs read on the edge, before they change
	always @(posedge clock) begin
		if (rstn && result_valid) begin
			match_result();
		end
	end

	task automatic report_missing();
		for (int i = 0; i < exp_lane_q.size(); i++) begin
			$display("Missing result for lane %0d, flushed at cycle %0d",
				exp_lane_q[i], exp_stamp_q[i]);
			other_errors++;
		end
	endtask

	task automatic print_counts();
		$display("Errors: value %0d, lane %0d, other %0d", value_errors, lane_errors,
			other_errors);
	endtask

	initial begin : watchdog
		@(posedge clock);
		while (timeout_cycles == 0 || cycle < timeout_cycles) begin
			@(posedge clock);
		end
		$display("Timeout after %0d cycles, %0d results outstanding", cycle, exp_lane_q.size());
		other_errors++;
		report_missing();
		print_counts();
		$display("** FAIL **");
		$finish;
	end

	initial begin
		void'($urandom(SEED));
		rstn         = 1'b0;
		job_sel      = '0;
		job_data     = '0;
		job_valid    = 1'b0;
		cycle        = 0;
		value_errors = 0;
		lane_errors  = 0;
		other_errors = 0;
		for (int l = 0; l < `GR_LANES; l++) begin
			model_acc[l] = '0;
		end
		build_table();
		// Reset, table length, then drain margin
		timeout_cycles = 16 + table_cycles + 64;
		repeat (16) @(posedge clock);
		rstn <= 1'b1;
		for (int i = 0; i < n_entries; i++) begin
			@(posedge clock);
			job_sel   <= tbl_lane[i];
			job_data  <= {tbl_op[i], tbl_operand[i]};
			job_valid <= 1'b1;
			apply_model(i);
			for (int g = 0; g < tbl_gap[i]; g++) begin
				@(posedge clock);
				drive_idle();
			end
		end
		@(posedge clock);
		drive_idle();
		while (exp_lane_q.size() != 0) begin
			@(posedge clock);
		end
		// Window for stray results
		repeat (12) @(posedge clock);
		report_missing();
		print_counts();
		if (value_errors + lane_errors + other_errors == 0) begin
			$display("** PASS **");
		end else begin
			$display("** FAIL **");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== source/graph_reduce_top.sv ====
// --------------------
// Top of the reduction fabric
// Demux to four lane engines, results merged by the collector
// --------------------

`timescale 1ns/10ps
`default_nettype none

`include "graph_reduce_defs.svh"

module graph_reduce_top (
	input  logic                        clock,
	input  logic                        rstn,
	input  graph_reduce_pkg::lane_sel_t job_sel,
	input  logic [`GR_DATA_WIDTH-1:0]   job_data,
	input  logic                        job_valid,
	output graph_reduce_pkg::value_t    result_value,
	output graph_reduce_pkg::lane_sel_t result_lane,
	output logic                        result_valid
);

	import graph_reduce_pkg::*;

	// Demux to lanes
	logic [`GR_DATA_WIDTH-1:0] lane_word [0:`GR_LANES-1];
	logic                      lane_word_valid [0:`GR_LANES-1];

	// Lanes to and from collector
	logic   lane_pending [0:`GR_LANES-1];
	value_t lane_held [0:`GR_LANES-1];
	logic   lane_grant [0:`GR_LANES-1];

	// --------------------
	// Fan-out
	// --------------------

	demux_bus #(
		.DATA_WIDTH (`GR_DATA_WIDTH),
		.BUS_WIDTH  (`GR_LANES)
	) u_demux (
		.clock          (clock),
		.rstn           (rstn),
		.sel_in         (job_sel),
		.data_in        (job_data),
		.data_in_valid  (job_valid),
		.data_out       (lane_word),
		.data_out_valid (lane_word_valid)
	);

	// One engine per lane
	for (genvar i = 0; i < `GR_LANES; i++) begin : g_lane
		lane_engine u_lane (
			.clock      (clock),
			.rstn       (rstn),
			.word_in    (lane_word[i]),
			.word_valid (lane_word_valid[i]),
			.grant      (lane_grant[i]),
			.pending    (lane_pending[i]),
			.held       (lane_held[i])
		);
	end

	// --------------------
	// Merge
	// --------------------

	result_collector u_collect (
		.clock        (clock),
		.rstn         (rstn),
		.pending      (lane_pending),
		.held         (lane_held),
		.grant        (lane_grant),
		.result_value (result_value),
		.result_lane  (result_lane),
		.result_valid (result_valid)
	);

endmodule

`default_nettype wire

// ==== source/result_collector.sv ====
// --------------------
// Round-robin collector of flushed lane results
// Grants one pending lane per cycle and registers its value and index
// --------------------

`timescale 1ns/10ps
`default_nettype none

`include "graph_reduce_defs.svh"

module result_collector (
	input  logic                        clock,
	input  logic                        rstn,
	input  logic                        pending [0:`GR_LANES-1],
	input  graph_reduce_pkg::value_t    held [0:`GR_LANES-1],
	output logic                        grant [0:`GR_LANES-1],
	output graph_reduce_pkg::value_t    result_value,
	output graph_reduce_pkg::lane_sel_t result_lane,
	output logic                        result_valid
);

	import graph_reduce_pkg::*;

	// Lane that has first claim next cycle
	lane_sel_t rr_ptr;
	lane_sel_t pick_lane;
	logic      pick_found;

	// --------------------
	// Arbitration
	// --------------------

	// Scan from the pointer, wrapping past the last lane
	always_comb begin : p_pick
		int idx;
		pick_found = 1'b0;
		pick_lane  = rr_ptr;
		for (int k = 0; k < `GR_LANES; k++) begin
			idx = (int'(rr_ptr) + k) % `GR_LANES;
			if (!pick_found && pending[idx]) begin
				pick_found = 1'b1;
				pick_lane  = lane_sel_t'(idx);
			end
		end
	end

	// Grant pulse in the same cycle pending is seen
	for (genvar i = 0; i < `GR_LANES; i++) begin : g_grant
		assign grant[i] = pick_found && (pick_lane == lane_sel_t'(i));
	end

	// --------------------
	// Pointer and output
	// --------------------

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			rr_ptr       <= '0;
			result_valid <= 1'b0;
		end else begin
			result_valid <= pick_found;
			// Skip past the winner so every lane gets a turn
			if (pick_found) begin
				rr_ptr <= pick_lane + 1'b1;
			end
		end
	end

	// Value and tag, qualified by result_valid
	always_ff @(posedge clock) begin
		if (pick_found) begin
			result_value <= held[pick_lane];
			result_lane  <= pick_lane;
		end
	end

endmodule

`default_nettype wire

// ==== source/lane_engine.sv ====
// --------------------
// Per-lane accumulator with opcode decode
// Flushed value waits in held until the collector grants it
// --------------------

`timescale 1ns/10ps
`default_nettype none

`include "graph_reduce_defs.svh"

module lane_engine (
	input  logic                      clock,
	input  logic                      rstn,
	input  logic [`GR_DATA_WIDTH-1:0] word_in,
	input  logic                      word_valid,
	input  logic                      grant,
	output logic                      pending,
	output graph_reduce_pkg::value_t  held
);

	import graph_reduce_pkg::*;

	lane_op_t op;
	value_t   operand;
	value_t   acc;
	value_t   acc_sum;
	value_t   acc_max;
	logic     do_flush;

	// --------------------
	// Word split and datapath
	// --------------------

	// Opcode from the top field
	assign op      = lane_op_t'(word_in[`GR_DATA_WIDTH-1 -: `GR_OP_WIDTH]);
	assign operand = word_in[`GR_VALUE_WIDTH-1:0];

	// Sum wraps at the accumulator width
	assign acc_sum = acc + operand;
	assign acc_max = (operand > acc) ? operand : acc;

	assign do_flush = word_valid && (op == OP_FLUSH);

	// --------------------
	// Accumulator
	// --------------------

	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			acc <= '0;
		end else if (word_valid) begin
			case (op)
				OP_ADD:   acc <= acc_sum;
				OP_MAX:   acc <= acc_max;
				// Clear and flush both restart from zero
				OP_CLEAR: acc <= '0;
				OP_FLUSH: acc <= '0;
				default:  acc <= acc;
			endcase
		end
	end

	// Snapshot of the accumulator at flush
	always_ff @(posedge clock) begin
		if (do_flush) begin
			held <= acc;
		end
	end

	// Pending level, a new flush wins over a grant
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			pending <= 1'b0;
		end else if (do_flush) begin
			pending <= 1'b1;
		end else if (grant) begin
			pending <= 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== source/demux_bus.sv ====
// --------------------
// Pipelined one-to-many demultiplexer
// Fixed 5-cycle latency, accepts a new word every cycle
// --------------------

`timescale 1ns/10ps
`default_nettype none

module demux_bus #(
	parameter int DATA_WIDTH = 32,
	parameter int BUS_WIDTH  = 4,
	localparam int SEL_WIDTH = $clog2(BUS_WIDTH)
) (
	input  logic                  clock,
	input  logic                  rstn,
	input  logic [SEL_WIDTH-1:0]  sel_in,
	input  logic [DATA_WIDTH-1:0] data_in,
	input  logic                  data_in_valid,
	output logic [DATA_WIDTH-1:0] data_out [0:BUS_WIDTH-1],
	output logic                  data_out_valid [0:BUS_WIDTH-1]
);

	// Input stages 1 and 2
	logic [SEL_WIDTH-1:0]  sel_s1;
	logic [SEL_WIDTH-1:0]  sel_s2;
	logic [DATA_WIDTH-1:0] data_s1;
	logic [DATA_WIDTH-1:0] data_s2;
	logic                  valid_s1;
	logic                  valid_s2;

	// Per-output stages 3 and 4
	logic [DATA_WIDTH-1:0] data_s3 [0:BUS_WIDTH-1];
	logic [DATA_WIDTH-1:0] data_s4 [0:BUS_WIDTH-1];
	logic                  valid_s3 [0:BUS_WIDTH-1];
	logic                  valid_s4 [0:BUS_WIDTH-1];

	// --------------------
	// Input register stages
	// --------------------

	// Select and strobe, cleared on reset
	always_ff @(posedge clock or negedge rstn) begin
		if (!rstn) begin
			sel_s1   <= '0;
			sel_s2   <= '0;
			valid_s1 <= 1'b0;
			valid_s2 <= 1'b0;
		end else begin
			sel_s1   <= sel_in;
			sel_s2   <= sel_s1;
			valid_s1 <= data_in_valid;
			valid_s2 <= valid_s1;
		end
	end

	// Payload only
	always_ff @(posedge clock) begin
		data_s1 <= data_in;
		data_s2 <= data_s1;
	end

	// --------------------
	// Decode and output stages
	// --------------------

	for (genvar i = 0; i < BUS_WIDTH; i++) begin : g_out
		// One-hot strobe for the selected output
		always_ff @(posedge clock or negedge rstn) begin
			if (!rstn) begin
				valid_s3[i]       <= 1'b0;
				valid_s4[i]       <= 1'b0;
				data_out_valid[i] <= 1'b0;
			end else begin
				valid_s3[i]       <= valid_s2 && (sel_s2 == SEL_WIDTH'(i));
				valid_s4[i]       <= valid_s3[i];
				data_out_valid[i] <= valid_s4[i];
			end
		end

		// Own data copy per output, eases fan-out timing
		always_ff @(posedge clock) begin
			data_s3[i]  <= data_s2;
			data_s4[i]  <= data_s3[i];
			data_out[i] <= data_s4[i];
		end
	end

endmodule

`default_nettype wire

// ==== source/graph_reduce_pkg.sv ====
// --------------------
// Shared types for the reduction fabric
// Imported inside module bodies, scoped names in port lists
// --------------------

`default_nettype none

`include "graph_reduce_defs.svh"

package graph_reduce_pkg;

	// Lane opcodes, top field of a job word
	typedef enum logic [`GR_OP_WIDTH-1:0] {
		OP_ADD   = 2'd0,
		OP_MAX   = 2'd1,
		OP_CLEAR = 2'd2,
		OP_FLUSH = 2'd3
	} lane_op_t;

	// Unsigned operand and accumulator
	typedef logic [`GR_VALUE_WIDTH-1:0] value_t;

	// Lane index
	typedef logic [`GR_SEL_WIDTH-1:0] lane_sel_t;

endpackage

`default_nettype wire

// ==== source/graph_reduce_defs.svh ====
// --------------------
// Widths and lane count for the reduction fabric
// Included by the package and by every RTL file that sizes a port
// --------------------

`ifndef GRAPH_REDUCE_DEFS_SVH
`define GRAPH_REDUCE_DEFS_SVH

// Job word layout
// Opcode sits in the top bits, operand in the low bits
`define GR_DATA_WIDTH  32
`define GR_OP_WIDTH    2
`define GR_VALUE_WIDTH 30

// Lane fan-out
`define GR_LANES       4
`define GR_SEL_WIDTH   2

`endif
